// File: vlog.f
source/sbPkg.sv
source/storeBuffer.sv
source/loadOrderCheck.sv
source/llscMonitor.sv
source/storeSubsystem.sv
verif/tbClockGen.sv
verif/storeSubsystemTb.sv

// File: Bender.yml
package:
  name: store_subsystem

sources:
  - source/sbPkg.sv
  - source/storeBuffer.sv
  - source/loadOrderCheck.sv
  - source/llscMonitor.sv
  - source/storeSubsystem.sv
  - target: simulation
    files:
      - verif/tbClockGen.sv
      - verif/storeSubsystemTb.sv

// File: verif/storeSubsystemTb.sv
module storeSubsystemTb;
    timeunit 1ns;
    timeprecision 100ps;
    import sbPkg::*;

    localparam int MAX_DRAIN = 100;
    localparam int RUN_CYCLES = 6 * (MAX_DRAIN + 60);

    logic Clk, rstN, stall, flush, dcAccept, dcDone, llSet;
    logic [SB_PTR_W-1:0] dcDonePtr, allocPtr;
    logic sbFull, sbEmpty, dcReq, redirect;
    logic [ADDR_W-1:0] llAddr, redirectPc;
    sbAllocReq alloc;
    sbRetire [RETIRE_PORTS-1:0] retire;
    loadProbe [LQ_DEPTH-1:0] loads;
    dcWrite dcOut;
    scResult scOut;

    // reference model of the buffer contents
    logic [SB_DEPTH-1:0] used;
    logic [SB_DEPTH-1:0] written;
    logic [ADDR_W-1:0] mAddr [SB_DEPTH];
    logic [DATA_W-1:0] mData [SB_DEPTH];
    logic [1:0] mMat [SB_DEPTH];
    logic mSc [SB_DEPTH];
    logic [TAG_W-1:0] mTag [SB_DEPTH];
    logic linkModel;
    logic [ADDR_W-1:0] linkAddrModel;
    scResult expScOut;
    dcWrite expectQ [$];
    logic [SB_PTR_W-1:0] doneQ [$];
    int dueQ [$];
    int acceptWait;
    int cycleCnt;
    logic [31:0] lcgState = 32'h5812_3caa;

    tbClockGen uClockGen (.Clk(Clk), .rstN(rstN));

    storeSubsystem UUT (
        .Clk(Clk), .rstN(rstN), .stall(stall), .flush(flush), .alloc(alloc),
        .retire(retire), .dcAccept(dcAccept), .dcDone(dcDone), .dcDonePtr(dcDonePtr),
        .loads(loads), .llSet(llSet), .llAddr(llAddr), .allocPtr(allocPtr),
        .sbFull(sbFull), .sbEmpty(sbEmpty), .dcReq(dcReq), .dcOut(dcOut),
        .scOut(scOut), .redirect(redirect), .redirectPc(redirectPc)
    );

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic comparePtr(string name, logic [SB_PTR_W-1:0] got, logic [SB_PTR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic comparePc(string name, logic [ADDR_W-1:0] got, logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic compareDcWrite(string name, dcWrite got, dcWrite exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic compareScResult(string name, scResult got, scResult exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abortRun();
        end
    endtask

    // cache model checks the head every cycle and accepts after a random delay
    always @(posedge Clk) begin
        if (rstN) begin
            cycleCnt++;
            if (dcReq && expectQ.size() == 0) begin
                $display("cache got a write request for entry %0d that was never expected",
                         dcOut.ptr);
                abortRun();
            end
            if (dcReq) begin
                compareDcWrite("dcOut", dcOut, expectQ[0]);
            end
            if (dcReq && dcAccept && !stall) begin
                void'(expectQ.pop_front());
                doneQ.push_back(dcOut.ptr);
                dueQ.push_back(cycleCnt + 1 + int'(nextRand() % 3));
                dcAccept <= 1'b0;
                acceptWait = int'(nextRand() % 4);
            end else if (dcReq && !dcAccept) begin
                if (acceptWait == 0) begin
                    dcAccept <= 1'b1;
                end else begin
                    acceptWait--;
                end
            end
            if (dcDone && !stall) begin
                used[doneQ[0]] = 1'b0;
                void'(doneQ.pop_front());
                void'(dueQ.pop_front());
            end
            if (doneQ.size() > 0 && cycleCnt >= dueQ[0]) begin
                dcDone    <= 1'b1;
                dcDonePtr <= doneQ[0];
            end else begin
                dcDone <= 1'b0;
            end
        end
    end

    task cycleStart();
        @(posedge Clk);
        alloc  <= '0;
        retire <= '0;
        llSet  <= 1'b0;
        flush  <= 1'b0;
    endtask

    function automatic logic [SB_PTR_W-1:0] lowestFree();
        logic [SB_PTR_W-1:0] r = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                r = SB_PTR_W'(i);
            end
        end
        return r;
    endfunction

    function automatic sbRetire retireOf(int ptr);
        return '{valid: 1'b1, ptr: SB_PTR_W'(ptr)};
    endfunction

    task automatic allocStore(input logic [ADDR_W-1:0] pc, input logic [ADDR_W-1:0] addr,
                              input logic isSc, input logic [TAG_W-1:0] tag, output int ptr);
        sbAllocReq req;
        logic [DATA_W-1:0] data;
        data = nextRand();
        req = '{valid: 1'b1, pc: pc, addr: addr, data: data, mat: addr[3:2], isSc: isSc,
                scTag: tag, robPtr: ROB_W'(nextRand())};
        cycleStart();
        alloc <= req;
        @(negedge Clk);
        comparePtr("allocPtr", allocPtr, lowestFree());
        ptr = int'(allocPtr);
        used[ptr] = 1'b1;
        written[ptr] = 1'b1;
        mAddr[ptr] = addr;
        mData[ptr] = data;
        mMat[ptr] = addr[3:2];
        mSc[ptr] = isSc;
        mTag[ptr] = tag;
    endtask

    // port 0 enters the commit order first
    task automatic retireStores(input sbRetire [RETIRE_PORTS-1:0] r);
        logic linkBefore;
        int ptr;
        dcWrite w;
        cycleStart();
        retire <= r;
        linkBefore = linkModel;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            if (r[p].valid) begin
                ptr = int'(r[p].ptr);
                written[ptr] = 1'b0;
                if (mSc[ptr]) begin
                    expScOut = '{valid: 1'b1, tag: mTag[ptr], success: linkBefore};
                end
                if (mSc[ptr] && !linkBefore) begin
                    used[ptr] = 1'b0;
                end else begin
                    w = '{addr: mAddr[ptr], data: mData[ptr], mat: mMat[ptr],
                          ptr: SB_PTR_W'(ptr)};
                    expectQ.push_back(w);
                end
                if (mSc[ptr] || mAddr[ptr] == linkAddrModel) begin
                    linkModel = 1'b0;
                end
            end
        end
    endtask

    task automatic waitEmpty();
        int n = 0;
        cycleStart();
        @(negedge Clk);
        while (!sbEmpty) begin
            n++;
            if (n > MAX_DRAIN) begin
                $display("store buffer did not drain within %0d cycles", MAX_DRAIN);
                abortRun();
            end
            @(negedge Clk);
        end
        if (expectQ.size() != 0) begin
            $display("buffer emptied with %0d expected cache writes missing", expectQ.size());
            abortRun();
        end
    endtask

    task automatic testResetAlloc();
        int ptr;
        @(negedge Clk);
        compareBit("sbEmpty", sbEmpty, 1'b1);
        compareBit("dcReq", dcReq, 1'b0);
        compareBit("redirect", redirect, 1'b0);
        compareBit("scOut.valid", scOut.valid, 1'b0);
        for (int i = 0; i < SB_DEPTH; i++) begin
            allocStore(32'h400 + i * 4, 32'h1000 + i * 16, 1'b0, '0, ptr);
            comparePtr("allocPtr", SB_PTR_W'(ptr), SB_PTR_W'(i));
        end
        cycleStart();
        @(negedge Clk);
        compareBit("sbFull", sbFull, 1'b1);
    endtask

    task automatic testRetireOrder();
        sbRetire [RETIRE_PORTS-1:0] r;
        r = '0;
        r[0] = retireOf(5);
        r[1] = retireOf(2);
        retireStores(r);
        r = '{retireOf(6), retireOf(3), retireOf(0), retireOf(7)};
        retireStores(r);
        r = '0;
        r[2] = retireOf(1);
        r[3] = retireOf(4);
        retireStores(r);
        waitEmpty();
    endtask

    task automatic testFlush();
        sbRetire [RETIRE_PORTS-1:0] r;
        int ptrs [7];
        for (int i = 0; i < 5; i++) begin
            allocStore(32'h800 + i * 4, 32'h3000 + i * 16, 1'b0, '0, ptrs[i]);
        end
        r = '0;
        r[0] = retireOf(ptrs[1]);
        r[1] = retireOf(ptrs[3]);
        retireStores(r);
        cycleStart();
        flush <= 1'b1;
        used = used & ~written;
        written = '0;
        // freed entries are handed out again
        allocStore(32'h900, 32'h3400, 1'b0, '0, ptrs[5]);
        allocStore(32'h904, 32'h3410, 1'b0, '0, ptrs[6]);
        r = '0;
        r[0] = retireOf(ptrs[6]);
        r[1] = retireOf(ptrs[5]);
        retireStores(r);
        waitEmpty();
    endtask

    task automatic testStall();
        sbRetire [RETIRE_PORTS-1:0] r;
        dcWrite held;
        int ptrs [3];
        for (int i = 0; i < 3; i++) begin
            allocStore(32'hA00 + i * 4, 32'h5000 + i * 16, 1'b0, '0, ptrs[i]);
        end
        r = '0;
        r[0] = retireOf(ptrs[0]);
        r[1] = retireOf(ptrs[1]);
        retireStores(r);
        cycleStart();
        stall <= 1'b1;
        retire[0] <= retireOf(ptrs[2]);
        @(negedge Clk);
        compareBit("dcReq", dcReq, 1'b1);
        // oldest retired store stays at the head
        held = '{addr: mAddr[ptrs[0]], data: mData[ptrs[0]], mat: mMat[ptrs[0]],
                 ptr: SB_PTR_W'(ptrs[0])};
        compareDcWrite("dcOut", dcOut, held);
        repeat (6) begin
            cycleStart();
            @(negedge Clk);
            compareDcWrite("dcOut", dcOut, held);
        end
        cycleStart();
        stall <= 1'b0;
        r = '0;
        r[0] = retireOf(ptrs[2]);
        retireStores(r);
        waitEmpty();
    endtask

    task automatic testRedirect();
        sbRetire [RETIRE_PORTS-1:0] r;
        int sA, sB, sC;
        cycleStart();
        loads[0] <= '{valid: 1'b1, executed: 1'b1, addr: 32'h6000};
        loads[1] <= '{valid: 1'b1, executed: 1'b1, addr: 32'h6020};
        loads[2] <= '{valid: 1'b1, executed: 1'b0, addr: 32'h6010};
        allocStore(32'hC00, 32'h6000, 1'b0, '0, sA);
        allocStore(32'hC04, 32'h6010, 1'b0, '0, sB);
        allocStore(32'hC08, 32'h6020, 1'b0, '0, sC);
        // matching a load that has not executed
        r = '0;
        r[0] = retireOf(sB);
        retireStores(r);
        cycleStart();
        @(negedge Clk);
        compareBit("redirect", redirect, 1'b0);
        r = '0;
        r[1] = retireOf(sC);
        r[2] = retireOf(sA);
        retireStores(r);
        cycleStart();
        @(negedge Clk);
        compareBit("redirect", redirect, 1'b1);
        comparePc("redirectPc", redirectPc, 32'hC08 + 32'd4);
        cycleStart();
        loads <= '0;
        @(negedge Clk);
        compareBit("redirect", redirect, 1'b0);
        waitEmpty();
    endtask

    task automatic setLink(logic [ADDR_W-1:0] addr);
        cycleStart();
        llSet <= 1'b1;
        llAddr <= addr;
        linkModel = 1'b1;
        linkAddrModel = addr;
    endtask

    task automatic testStoreConditional();
        sbRetire [RETIRE_PORTS-1:0] r;
        int ps, pa;
        setLink(32'h7000);
        allocStore(32'hE00, 32'h7000, 1'b1, 7'h15, ps);
        r = '0;
        r[0] = retireOf(ps);
        retireStores(r);
        cycleStart();
        @(negedge Clk);
        compareScResult("scOut", scOut, expScOut);
        waitEmpty();
        // a store to the linked address breaks the reservation
        setLink(32'h7000);
        allocStore(32'hE10, 32'h7000, 1'b0, '0, pa);
        allocStore(32'hE14, 32'h7000, 1'b1, 7'h16, ps);
        r = '0;
        r[0] = retireOf(pa);
        retireStores(r);
        r = '0;
        r[0] = retireOf(ps);
        retireStores(r);
        cycleStart();
        @(negedge Clk);
        compareScResult("scOut", scOut, expScOut);
        waitEmpty();
    endtask

    initial begin
        #(RUN_CYCLES * 10);
        $display("watchdog expired after %0d cycles, tests did not finish", RUN_CYCLES);
        abortRun();
    end

    initial begin
        alloc = '0;
        retire = '0;
        loads = '0;
        stall = 1'b0;
        flush = 1'b0;
        dcAccept = 1'b0;
        dcDone = 1'b0;
        dcDonePtr = '0;
        llSet = 1'b0;
        llAddr = '0;
        used = '0;
        written = '0;
        linkModel = 1'b0;
        linkAddrModel = '0;
        acceptWait = 0;
        cycleCnt = 0;
        @(posedge rstN);
        testResetAlloc();
        testRetireOrder();
        testFlush();
        testStall();
        testRedirect();
        testStoreConditional();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verif/tbClockGen.sv
module tbClockGen (
    output logic Clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // reset held for four rising edges
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge Clk);
        rstN <= 1'b1;
    end

endmodule

// File: source/storeSubsystem.sv
module storeSubsystem (
    input  logic                                         Clk,
    input  logic                                         rstN,
    input  logic                                         stall,
    input  logic                                         flush,
    input  sbPkg::sbAllocReq                             alloc,
    input  sbPkg::sbRetire [sbPkg::RETIRE_PORTS-1:0]     retire,
    input  logic                                         dcAccept,
    input  logic                                         dcDone,
    input  logic [sbPkg::SB_PTR_W-1:0]                   dcDonePtr,
    input  sbPkg::loadProbe [sbPkg::LQ_DEPTH-1:0]        loads,
    input  logic                                         llSet,
    input  logic [sbPkg::ADDR_W-1:0]                     llAddr,
    output logic [sbPkg::SB_PTR_W-1:0]                   allocPtr,
    output logic                                         sbFull,
    output logic                                         sbEmpty,
    output logic                                         dcReq,
    output sbPkg::dcWrite                                dcOut,
    output sbPkg::scResult                               scOut,
    output logic                                         redirect,
    output logic [sbPkg::ADDR_W-1:0]                     redirectPc
);
    import sbPkg::*;

    retireInfo [RETIRE_PORTS-1:0] retireOut;
    scRetireSel                   scRetire;
    logic                         linkValid;

    storeBuffer uStoreBuffer (
        .Clk(Clk), .rstN(rstN), .stall(stall), .flush(flush),
        .alloc(alloc), .retire(retire),
        .dcAccept(dcAccept), .dcDone(dcDone), .dcDonePtr(dcDonePtr),
        .linkValid(linkValid),
        .allocPtr(allocPtr), .sbFull(sbFull), .sbEmpty(sbEmpty),
        .dcReq(dcReq), .dcOut(dcOut), .scOut(scOut),
        .retireOut(retireOut), .scRetire(scRetire)
    );

    loadOrderCheck uLoadOrderCheck (
        .Clk(Clk), .rstN(rstN), .retireOut(retireOut), .loads(loads),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    llscMonitor uLlscMonitor (
        .Clk(Clk), .rstN(rstN), .llSet(llSet), .llAddr(llAddr),
        .retireOut(retireOut), .scRetire(scRetire), .linkValid(linkValid)
    );

endmodule

// File: source/llscMonitor.sv
module llscMonitor (
    input  logic                                         Clk,
    input  logic                                         rstN,
    input  logic                                         llSet,
    input  logic [sbPkg::ADDR_W-1:0]                     llAddr,
    input  sbPkg::retireInfo [sbPkg::RETIRE_PORTS-1:0]   retireOut,
    input  sbPkg::scRetireSel                            scRetire,
    output logic                                         linkValid
);
    import sbPkg::*;

    logic [ADDR_W-1:0]       linkAddr;
    logic [RETIRE_PORTS-1:0] addrHit;
    logic [RETIRE_PORTS-1:0] setHit;
    logic                    linkKill;

    always_comb begin
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            addrHit[p] = retireOut[p].valid && (retireOut[p].addr == linkAddr);
            setHit[p]  = retireOut[p].valid && (retireOut[p].addr == llAddr);
        end
    end

    // any SC retirement ends the reservation
    assign linkKill = scRetire.valid || (|addrHit);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            linkValid <= 1'b0;
        end else if (llSet) begin
            linkValid <= 1'b1;
        end else if (linkKill) begin
            linkValid <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (llSet) begin
            linkAddr <= llAddr;
        end
    end

    // a new link never lands on a store retiring to the same address
    llSetNoStore: assert property (@(posedge Clk) disable iff (!rstN)
        llSet |-> !(|setHit));

endmodule

// File: source/loadOrderCheck.sv
module loadOrderCheck (
    input  logic                                         Clk,
    input  logic                                         rstN,
    input  sbPkg::retireInfo [sbPkg::RETIRE_PORTS-1:0]   retireOut,
    input  sbPkg::loadProbe [sbPkg::LQ_DEPTH-1:0]        loads,
    output logic                                         redirect,
    output logic [sbPkg::ADDR_W-1:0]                     redirectPc
);
    import sbPkg::*;

    logic [RETIRE_PORTS-1:0] portHit;
    logic [ADDR_W-1:0]       hitPc;
    logic                    anyHit;

    // every retiring store against every executed load
    always_comb begin
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            portHit[p] = 1'b0;
            for (int l = 0; l < LQ_DEPTH; l++) begin
                if (loads[l].valid && loads[l].executed &&
                    loads[l].addr == retireOut[p].addr) begin
                    portHit[p] = retireOut[p].valid;
                end
            end
        end
    end

    // lowest matching port supplies the pc
    always_comb begin
        hitPc = '0;
        for (int p = RETIRE_PORTS - 1; p >= 0; p--) begin
            if (portHit[p]) begin
                hitPc = retireOut[p].pc;
            end
        end
    end

    assign anyHit = |portHit;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            redirect <= 1'b0;
        end else begin
            redirect <= anyHit;
        end
    end

    // refetch after the store
    always_ff @(posedge Clk) begin
        if (anyHit) begin
            redirectPc <= hitPc + ADDR_W'(4);
        end
    end

endmodule

// File: source/storeBuffer.sv
module storeBuffer (
    input  logic                                         Clk,
    input  logic                                         rstN,
    input  logic                                         stall,
    input  logic                                         flush,
    input  sbPkg::sbAllocReq                             alloc,
    input  sbPkg::sbRetire [sbPkg::RETIRE_PORTS-1:0]     retire,
    input  logic                                         dcAccept,
    input  logic                                         dcDone,
    input  logic [sbPkg::SB_PTR_W-1:0]                   dcDonePtr,
    input  logic                                         linkValid,
    output logic [sbPkg::SB_PTR_W-1:0]                   allocPtr,
    output logic                                         sbFull,
    output logic                                         sbEmpty,
    output logic                                         dcReq,
    output sbPkg::dcWrite                                dcOut,
    output sbPkg::scResult                               scOut,
    output sbPkg::retireInfo [sbPkg::RETIRE_PORTS-1:0]   retireOut,
    output sbPkg::scRetireSel                            scRetire
);
    import sbPkg::*;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [1:0]        mat;
        logic              isSc;
        logic [TAG_W-1:0]  scTag;
    } sbEntry;

    sbEntry entries [SB_DEPTH];
    sbState state [SB_DEPTH];
    sbState stateNext [SB_DEPTH];

    // commit-order queue of entry pointers
    logic [SB_PTR_W-1:0] orderQ [SB_DEPTH];
    logic [SB_PTR_W-1:0] qHead;
    logic [SB_PTR_W-1:0] qTail;
    logic [SB_PTR_W:0]   qCount;

    logic [RETIRE_PORTS-1:0] retValid;
    logic [RETIRE_PORTS-1:0] isScPort;
    logic [RETIRE_PORTS-1:0] scOk;
    logic [RETIRE_PORTS-1:0] pushEn;
    logic [SB_PTR_W-1:0]     pushIdx [RETIRE_PORTS];
    logic [SB_PTR_W:0]       pushCount;
    logic                    pop;
    logic                    allocEn;

    // lowest free entry wins
    always_comb begin
        allocPtr = '0;
        sbFull   = 1'b1;
        sbEmpty  = 1'b1;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == SB_FREE) begin
                allocPtr = SB_PTR_W'(i);
                sbFull   = 1'b0;
            end else begin
                sbEmpty = 1'b0;
            end
        end
    end

    assign allocEn = alloc.valid && !stall && !flush;
    assign dcReq   = (qCount != '0);
    assign pop     = dcReq && dcAccept && !stall;

    // retire ports, SC resolved against the link
    always_comb begin
        scRetire = '0;
        for (int p = RETIRE_PORTS - 1; p >= 0; p--) begin
            retValid[p] = retire[p].valid && !stall;
            isScPort[p] = entries[retire[p].ptr].isSc;
            if (retValid[p] && isScPort[p]) begin
                scRetire.valid = 1'b1;
                scRetire.port  = RP_W'(p);
            end
        end
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            scOk[p]            = linkValid && (scRetire.port == RP_W'(p));
            pushEn[p]          = retValid[p] && (!isScPort[p] || scOk[p]);
            retireOut[p].valid = pushEn[p];
            retireOut[p].addr  = entries[retire[p].ptr].addr;
            retireOut[p].pc    = entries[retire[p].ptr].pc;
        end
    end

    // port 0 lands first in the queue
    always_comb begin
        pushCount = '0;
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            pushIdx[p] = qTail + pushCount[SB_PTR_W-1:0];
            pushCount  = pushCount + (SB_PTR_W + 1)'(pushEn[p]);
        end
    end

    always_comb begin
        stateNext = state;
        if (!stall) begin
            if (allocEn) begin
                stateNext[allocPtr] = SB_WRITTEN;
            end
            for (int p = 0; p < RETIRE_PORTS; p++) begin
                if (retValid[p]) begin
                    // failed SC is dropped here
                    stateNext[retire[p].ptr] = pushEn[p] ? SB_COMMITTED : SB_FREE;
                end
            end
            if (flush) begin
                for (int i = 0; i < SB_DEPTH; i++) begin
                    if (stateNext[i] == SB_WRITTEN) begin
                        stateNext[i] = SB_FREE;
                    end
                end
            end
            if (pop) begin
                stateNext[orderQ[qHead]] = SB_ISSUED;
            end
            if (dcDone) begin
                stateNext[dcDonePtr] = SB_FREE;
            end
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                state[i] <= SB_FREE;
            end
            qHead  <= '0;
            qTail  <= '0;
            qCount <= '0;
            scOut  <= '0;
        end else begin
            state <= stateNext;
            if (!stall) begin
                qTail  <= qTail + pushCount[SB_PTR_W-1:0];
                qCount <= qCount + pushCount - (SB_PTR_W + 1)'(pop);
                if (pop) begin
                    qHead <= qHead + 1'b1;
                end
                scOut.valid   <= scRetire.valid;
                scOut.tag     <= entries[retire[scRetire.port].ptr].scTag;
                scOut.success <= scOk[scRetire.port];
            end else begin
                scOut.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (allocEn) begin
            entries[allocPtr] <= '{pc: alloc.pc, addr: alloc.addr, data: alloc.data,
                                   mat: alloc.mat, isSc: alloc.isSc, scTag: alloc.scTag};
        end
        for (int p = 0; p < RETIRE_PORTS; p++) begin
            if (pushEn[p]) begin
                orderQ[pushIdx[p]] <= retire[p].ptr;
            end
        end
    end

    // head of queue to the cache
    assign dcOut.addr = entries[orderQ[qHead]].addr;
    assign dcOut.data = entries[orderQ[qHead]].data;
    assign dcOut.mat  = entries[orderQ[qHead]].mat;
    assign dcOut.ptr  = orderQ[qHead];

    allocNotFull: assert property (@(posedge Clk) disable iff (!rstN)
        alloc.valid |-> !sbFull);

    for (genvar p = 0; p < RETIRE_PORTS; p++) begin : gRetireChk
        retireWritten: assert property (@(posedge Clk) disable iff (!rstN)
            retValid[p] |-> state[retire[p].ptr] == SB_WRITTEN);
    end

    doneIssued: assert property (@(posedge Clk) disable iff (!rstN)
        dcDone && !stall |-> state[dcDonePtr] == SB_ISSUED);

endmodule

// File: source/sbPkg.sv
package sbPkg;

    // buffer and port sizes
    localparam int SB_DEPTH     = 8;
    localparam int SB_PTR_W     = 3;
    localparam int RETIRE_PORTS = 4;
    localparam int RP_W         = 2;
    localparam int LQ_DEPTH     = 8;
    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 32;
    localparam int TAG_W        = 7;
    localparam int ROB_W        = 6;

    typedef enum logic [1:0] {
        SB_FREE      = 2'd0,
        SB_WRITTEN   = 2'd1,
        SB_COMMITTED = 2'd2,
        SB_ISSUED    = 2'd3
    } sbState;

    // from address generation
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [1:0]        mat;
        logic              isSc;
        logic [TAG_W-1:0]  scTag;
        logic [ROB_W-1:0]  robPtr;
    } sbAllocReq;

    typedef struct packed {
        logic                valid;
        logic [SB_PTR_W-1:0] ptr;
    } sbRetire;

    typedef struct packed {
        logic              valid;
        logic              executed;
        logic [ADDR_W-1:0] addr;
    } loadProbe;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] pc;
    } retireInfo;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [1:0]          mat;
        logic [SB_PTR_W-1:0] ptr;
    } dcWrite;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic             success;
    } scResult;

    // which retire port carries the store-conditional
    typedef struct packed {
        logic            valid;
        logic [RP_W-1:0] port;
    } scRetireSel;

endpackage
